// ==== logic/wdist_consts.svh ====
`ifndef WDIST_CONSTS_SVH
`define WDIST_CONSTS_SVH

// ========================================
// PEC array
// ========================================
`define WDIST_NUM_PEC       8
`define WDIST_PEC_IDX_W     3

// Weight word and per-PEC quota
`define WDIST_WEI_W         16
`define WDIST_WEI_PER_PEC   4
`define WDIST_ROUND_W       2

// Weight queue sizing
`define WDIST_FIFO_DEPTH    16
`define WDIST_FIFO_LVL_W    5

// Pipeline pre-fill before the first offer
`define WDIST_PREFILL_CYC   3

// ========================================
// APB register map
// ========================================
`define WDIST_APB_AW        4
`define WDIST_ADDR_WEI      4'h0
`define WDIST_ADDR_CMD      4'h4
`define WDIST_ADDR_STAT     4'h8

`endif

// ==== logic/wdist_pkg.sv ====
`default_nettype none

package wdist_pkg;

    // ========================================
    // Controller states
    // ========================================
    // Encoding is visible in status bits 1:0
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_PREFILL  = 2'd1,
        ST_DISPATCH = 2'd2,
        ST_DONE     = 2'd3
    } wdist_state_e;

    // ========================================
    // Command register opcodes
    // ========================================
    // Carried in the low two bits of a command write
    // Value 3 is unassigned and rejected
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_START = 2'd1,
        CMD_ABORT = 2'd2
    } wdist_cmd_e;

endpackage

`default_nettype wire

// ==== logic/wdist_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_apb_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    // APB slave
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`WDIST_APB_AW-1:0]       paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    // Live status sources
    input  logic                           fifo_full,
    input  wdist_pkg::wdist_state_e        state,
    input  logic [`WDIST_PEC_IDX_W-1:0]    pec_idx,
    input  logic [`WDIST_ROUND_W-1:0]      round,
    input  logic [`WDIST_FIFO_LVL_W-1:0]   fifo_level,
    // Towards FIFO and controller
    output logic                           push,
    output logic [`WDIST_WEI_W-1:0]        push_data,
    output logic                           start_cmd,
    output logic                           abort_cmd
);

    import wdist_pkg::*;

    logic        setup_ph;
    logic        access_ph;
    logic        hit_wei;
    logic        hit_cmd;
    logic        hit_stat;
    logic        start_ok;
    wdist_cmd_e  cmd;
    logic [31:0] stat_word;

    // Zero wait states
    assign pready    = 1'b1;
    assign setup_ph  = psel && !penable;
    assign access_ph = psel && penable;

    // Address decode
    assign hit_wei  = (paddr == `WDIST_ADDR_WEI);
    assign hit_cmd  = (paddr == `WDIST_ADDR_CMD);
    assign hit_stat = (paddr == `WDIST_ADDR_STAT);

    assign cmd       = wdist_cmd_e'(pwdata[1:0]);
    assign push_data = pwdata[`WDIST_WEI_W-1:0];

    // START only from a quiet controller
    assign start_ok = (state == ST_IDLE) || (state == ST_DONE);

    // ========================================
    // Access phase decode
    // ========================================
    always_comb begin
        push      = 1'b0;
        start_cmd = 1'b0;
        abort_cmd = 1'b0;
        pslverr   = 1'b0;
        if (access_ph) begin
            if (pwrite) begin
                if (hit_wei) begin
                    // Full queue drops the word
                    if (fifo_full) begin
                        pslverr = 1'b1;
                    end else begin
                        push = 1'b1;
                    end
                end else if (hit_cmd) begin
                    case (cmd)
                        CMD_NOP:   pslverr = 1'b0;
                        CMD_START: begin
                            if (start_ok) begin
                                start_cmd = 1'b1;
                            end else begin
                                pslverr = 1'b1;
                            end
                        end
                        CMD_ABORT: abort_cmd = 1'b1;
                        default:   pslverr = 1'b1;
                    endcase
                end else begin
                    // Status is read only, rest unmapped
                    pslverr = 1'b1;
                end
            end else if (!(hit_wei || hit_cmd || hit_stat)) begin
                pslverr = 1'b1;
            end
        end
    end

    // Status word fields
    always_comb begin
        stat_word                          = '0;
        stat_word[1:0]                     = state;
        stat_word[4 +: `WDIST_PEC_IDX_W]   = pec_idx;
        stat_word[8 +: `WDIST_ROUND_W]     = round;
        stat_word[16 +: `WDIST_FIFO_LVL_W] = fifo_level;
    end

    // Read data captured in setup phase, valid in access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (setup_ph && !pwrite) begin
            prdata <= hit_stat ? stat_word : 32'h0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdist_wei_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_wei_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  logic [`WDIST_WEI_W-1:0]        push_data,
    input  logic                           pop,
    input  logic                           flush,
    output logic [`WDIST_WEI_W-1:0]        head_wei,
    output logic                           empty,
    output logic                           full,
    output logic [`WDIST_FIFO_LVL_W-1:0]   level
);

    // Depth is a power of two, pointers wrap on their own
    localparam int PTR_W = `WDIST_FIFO_LVL_W - 1;

    logic [`WDIST_WEI_W-1:0]      mem [`WDIST_FIFO_DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [`WDIST_FIFO_LVL_W-1:0] count;
    logic                         do_push;
    logic                         do_pop;

    assign full  = (count == `WDIST_FIFO_LVL_W'(`WDIST_FIFO_DEPTH));
    assign empty = (count == '0);
    assign level = count;

    // Qualified requests
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head word, offered straight from storage
    assign head_wei = mem[rd_ptr];

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Drop everything at once
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves level alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdist_cursor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_cursor (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           timer_load,
    input  logic                           advance,
    input  logic                           clear,
    output logic                           timer_zero,
    output logic [`WDIST_PEC_IDX_W-1:0]    pec_idx,
    output logic [`WDIST_ROUND_W-1:0]      round,
    output logic                           last_handout
);

    localparam int          TMR_W      = $clog2(`WDIST_PREFILL_CYC + 1);
    localparam int unsigned LAST_PEC   = `WDIST_NUM_PEC - 1;
    localparam int unsigned LAST_ROUND = `WDIST_WEI_PER_PEC - 1;
    localparam int unsigned TMR_INIT   = `WDIST_PREFILL_CYC - 1;

    logic [TMR_W-1:0] timer;
    logic             pec_wrap;

    assign timer_zero = (timer == '0);
    assign pec_wrap   = (pec_idx == LAST_PEC[`WDIST_PEC_IDX_W-1:0]);

    // Final PEC of the final round
    assign last_handout = pec_wrap && (round == LAST_ROUND[`WDIST_ROUND_W-1:0]);

    // ========================================
    // Pre-fill down-counter
    // ========================================
    // Zero is reached on the last pre-fill cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
        end else if (timer_load) begin
            timer <= TMR_INIT[TMR_W-1:0];
        end else if (clear) begin
            timer <= '0;
        end else if (!timer_zero) begin
            timer <= timer - 1'b1;
        end
    end

    // PEC index and round, round bumps on index wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pec_idx <= '0;
            round   <= '0;
        end else if (clear) begin
            pec_idx <= '0;
            round   <= '0;
        end else if (advance) begin
            if (pec_wrap) begin
                pec_idx <= '0;
                round   <= round + 1'b1;
            end else begin
                pec_idx <= pec_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdist_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_ctrl_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_cmd,
    input  logic                           abort_cmd,
    input  logic                           empty,
    input  logic [`WDIST_WEI_W-1:0]        head_wei,
    input  logic                           timer_zero,
    input  logic [`WDIST_PEC_IDX_W-1:0]    pec_idx,
    input  logic                           last_handout,
    input  logic [`WDIST_NUM_PEC-1:0]      get_wei,
    output wdist_pkg::wdist_state_e        state,
    output logic                           fifo_pop,
    output logic                           fifo_flush,
    output logic                           timer_load,
    output logic                           advance,
    output logic                           clear,
    output logic [`WDIST_NUM_PEC-1:0]      rdy_wei,
    output logic [`WDIST_WEI_W-1:0]        wei_data,
    output logic                           done
);

    import wdist_pkg::*;

    wdist_state_e              state_nxt;
    logic                      get_hit;
    logic                      offer_go;
    logic [`WDIST_NUM_PEC-1:0] offer_vec;

    // Only a get on the offered PEC counts
    assign get_hit = |(get_wei & rdy_wei);

    // New offer once the previous one has dropped
    assign offer_go  = (state == ST_DISPATCH) && (rdy_wei == '0) && !empty && !abort_cmd;
    assign offer_vec = {{(`WDIST_NUM_PEC-1){1'b0}}, 1'b1} << pec_idx;

    assign done = (state == ST_DONE);

    // ========================================
    // Next state and strobes
    // ========================================
    always_comb begin
        state_nxt  = state;
        fifo_pop   = 1'b0;
        fifo_flush = 1'b0;
        timer_load = 1'b0;
        advance    = 1'b0;
        clear      = 1'b0;
        if (abort_cmd) begin
            // Abort wins over everything
            state_nxt  = ST_IDLE;
            fifo_flush = 1'b1;
            clear      = 1'b1;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start_cmd) begin
                        state_nxt  = ST_PREFILL;
                        timer_load = 1'b1;
                        clear      = 1'b1;
                    end
                end
                ST_PREFILL: begin
                    if (timer_zero) begin
                        state_nxt = ST_DISPATCH;
                    end
                end
                ST_DISPATCH: begin
                    if (get_hit) begin
                        fifo_pop = 1'b1;
                        advance  = 1'b1;
                        if (last_handout) begin
                            state_nxt = ST_DONE;
                        end
                    end
                end
                default: state_nxt = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // One-hot offer, drops the edge after a get
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_wei <= '0;
        end else if (abort_cmd || get_hit) begin
            rdy_wei <= '0;
        end else if (offer_go) begin
            rdy_wei <= offer_vec;
        end
    end

    // Weight latched with the offer, held until the get
    always_ff @(posedge clk) begin
        if (offer_go) begin
            wei_data <= head_wei;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdist_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // APB slave
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`WDIST_APB_AW-1:0]       paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    // PEC side
    input  logic [`WDIST_NUM_PEC-1:0]      get_wei,
    output logic [`WDIST_NUM_PEC-1:0]      rdy_wei,
    output logic [`WDIST_WEI_W-1:0]        wei_data,
    output logic                           done
);

    import wdist_pkg::*;

    // ========================================
    // Internal nets
    // ========================================
    wdist_state_e                 state;
    logic                         push;
    logic [`WDIST_WEI_W-1:0]      push_data;
    logic                         start_cmd;
    logic                         abort_cmd;
    logic                         fifo_pop;
    logic                         fifo_flush;
    logic [`WDIST_WEI_W-1:0]      head_wei;
    logic                         empty;
    logic                         full;
    logic [`WDIST_FIFO_LVL_W-1:0] level;
    logic                         timer_load;
    logic                         advance;
    logic                         clear;
    logic                         timer_zero;
    logic [`WDIST_PEC_IDX_W-1:0]  pec_idx;
    logic [`WDIST_ROUND_W-1:0]    round;
    logic                         last_handout;

    // Host register block
    wdist_apb_regs i_wdist_apb_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fifo_full  (full),
        .state      (state),
        .pec_idx    (pec_idx),
        .round      (round),
        .fifo_level (level),
        .push       (push),
        .push_data  (push_data),
        .start_cmd  (start_cmd),
        .abort_cmd  (abort_cmd)
    );

    // Weight queue
    wdist_wei_fifo i_wdist_wei_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (fifo_pop),
        .flush     (fifo_flush),
        .head_wei  (head_wei),
        .empty     (empty),
        .full      (full),
        .level     (level)
    );

    // Pre-fill timer and round-robin cursor
    wdist_cursor i_wdist_cursor (
        .clk          (clk),
        .rst_n        (rst_n),
        .timer_load   (timer_load),
        .advance      (advance),
        .clear        (clear),
        .timer_zero   (timer_zero),
        .pec_idx      (pec_idx),
        .round        (round),
        .last_handout (last_handout)
    );

    wdist_ctrl_fsm i_wdist_ctrl_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_cmd    (start_cmd),
        .abort_cmd    (abort_cmd),
        .empty        (empty),
        .head_wei     (head_wei),
        .timer_zero   (timer_zero),
        .pec_idx      (pec_idx),
        .last_handout (last_handout),
        .get_wei      (get_wei),
        .state        (state),
        .fifo_pop     (fifo_pop),
        .fifo_flush   (fifo_flush),
        .timer_load   (timer_load),
        .advance      (advance),
        .clear        (clear),
        .rdy_wei      (rdy_wei),
        .wei_data     (wei_data),
        .done         (done)
    );

endmodule

`default_nettype wire

// ==== tests/wdist_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_asserts (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [`WDIST_NUM_PEC-1:0] rdy_wei,
    input  wire logic [`WDIST_NUM_PEC-1:0] get_wei,
    input  wire logic [`WDIST_WEI_W-1:0]   wei_data
);

    // ========================================
    // Offer protocol
    // ========================================
    // At most one PEC offered at a time
    a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rdy_wei))
        else $error("rdy_wei has more than one bit set");

    // Offered weight holds while the offer stands
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy_wei != '0) |=> $stable(wei_data))
        else $error("wei_data changed during an offer");

    // Matching get drops the offer on the next edge
    a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (|(get_wei & rdy_wei)) |=> (rdy_wei == '0))
        else $error("rdy_wei still high after a matching get");

endmodule

bind wdist_ctrl_fsm wdist_asserts i_wdist_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdy_wei  (rdy_wei),
    .get_wei  (get_wei),
    .wei_data (wei_data)
);

`default_nettype wire

// ==== tests/wdist_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wdist_consts.svh"

module wdist_tb;

    import wdist_pkg::*;

    localparam int NUM_HANDOUT = 35;
    localparam int CYCLE_LIMIT = 40 * NUM_HANDOUT + 500;
    localparam int RUN_HANDOUT = `WDIST_NUM_PEC * `WDIST_WEI_PER_PEC;

    logic                         clk;
    logic                         rst_n;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [`WDIST_APB_AW-1:0]     paddr;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic [`WDIST_NUM_PEC-1:0]    get_wei;
    logic [`WDIST_NUM_PEC-1:0]    rdy_wei;
    logic [`WDIST_WEI_W-1:0]      wei_data;
    logic                         done;

    logic [31:0] golden [0:68];
    int          cycles;
    int          n_hand;
    int          err_cnt;
    logic        pec_on;

    wdist_top i_wdist_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .get_wei  (get_wei),
        .rdy_wei  (rdy_wei),
        .wei_data (wei_data),
        .done     (done)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure("Timeout: the run exceeded its cycle limit");
        end
    end

    // ========================================
    // Failure and compare tasks
    // ========================================
    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_wei(input string name, input logic [`WDIST_WEI_W-1:0] got,
                             input logic [`WDIST_WEI_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_pec(input string name, input logic [`WDIST_PEC_IDX_W-1:0] got,
                             input logic [`WDIST_PEC_IDX_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_state(input wdist_pkg::wdist_state_e got,
                               input wdist_pkg::wdist_state_e exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch state: got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // One-hot ready vector to PEC number
    function automatic logic [`WDIST_PEC_IDX_W-1:0] pec_index(
        input logic [`WDIST_NUM_PEC-1:0] vec);
        logic [`WDIST_PEC_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < `WDIST_NUM_PEC; i++) begin
            if (vec[i]) begin
                idx = i[`WDIST_PEC_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    // ========================================
    // APB driver
    // ========================================
    // Sampled mid-cycle in the access phase
    task automatic apb_access(input logic wr, input logic [`WDIST_APB_AW-1:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        // Zero wait states
        check_bit("pready", pready, 1'b1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [`WDIST_APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_bit("pslverr", err, exp_err);
    endtask

    task automatic read_status(output logic [31:0] stat);
        logic err;
        apb_access(1'b0, `WDIST_ADDR_STAT, 32'h0, stat, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic wait_offer;
        @(negedge clk);
        while (rdy_wei == '0) begin
            @(negedge clk);
        end
    endtask

    // ========================================
    // PEC responder
    // ========================================
    // Takes each offer after 0 to 5 cycles, checks it against the golden handout
    initial begin
        int unsigned delay;
        logic [31:0] exp;
        forever begin
            @(negedge clk);
            if (pec_on && rdy_wei != '0) begin
                exp = golden[32 + n_hand];
                check_pec("pec_idx", pec_index(rdy_wei), exp[18:16]);
                check_wei("wei_data", wei_data, exp[15:0]);
                delay = $urandom % 6;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                get_wei <= rdy_wei;
                @(posedge clk);
                get_wei <= '0;
                n_hand++;
            end
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [31:0] stat;
        logic [31:0] rdata;
        logic        err;
        int          idx;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        get_wei = '0;
        cycles  = 0;
        n_hand  = 0;
        err_cnt = 0;
        pec_on  = 1'b0;
        void'($urandom(32'he1c9_348e));
        $readmemh("tests/wdist_golden.txt", golden);
        if ($isunknown(golden[68])) begin
            report_failure("Golden data file could not be read completely");
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state and status word
        read_status(stat);
        check_state(wdist_state_e'(stat[1:0]), ST_IDLE);
        check_pec("status pec_idx", stat[6:4], 3'd0);
        check_bit("status round nonzero", |stat[9:8], 1'b0);
        check_bit("status level nonzero", |stat[20:16], 1'b0);
        check_bit("rdy_wei any", |rdy_wei, 1'b0);
        check_bit("done", done, 1'b0);

        // Round-robin run, 16 preloaded then topped up
        for (int i = 0; i < 16; i++) begin
            apb_write(`WDIST_ADDR_WEI, golden[i], 1'b0);
        end
        pec_on = 1'b1;
        apb_write(`WDIST_ADDR_CMD, {30'h0, CMD_START}, 1'b0);
        idx = 16;
        while (idx < RUN_HANDOUT) begin
            read_status(stat);
            if (stat[20:16] < 5'd16) begin
                apb_write(`WDIST_ADDR_WEI, golden[idx], 1'b0);
                idx++;
            end
        end
        while (n_hand < RUN_HANDOUT) begin
            @(negedge clk);
        end
        check_bit("done", done, 1'b1);
        pec_on = 1'b0;

        // Empty FIFO holds dispatch
        apb_write(`WDIST_ADDR_CMD, {30'h0, CMD_START}, 1'b0);
        repeat (20) begin
            @(negedge clk);
            check_bit("rdy_wei any", |rdy_wei, 1'b0);
        end
        read_status(stat);
        check_state(wdist_state_e'(stat[1:0]), ST_DISPATCH);
        apb_write(`WDIST_ADDR_WEI, golden[68], 1'b0);
        wait_offer();
        check_pec("pec_idx", pec_index(rdy_wei), 3'd0);
        check_wei("wei_data", wei_data, golden[68][15:0]);

        // APB errors, FIFO first filled to 16
        for (int i = 0; i < 15; i++) begin
            apb_write(`WDIST_ADDR_WEI, golden[i], 1'b0);
        end
        for (int k = 64; k < 68; k++) begin
            apb_access(golden[k][28], golden[k][27:24], {8'h0, golden[k][23:0]}, rdata, err);
            check_bit("pslverr", err, 1'b1);
        end
        read_status(stat);
        check_state(wdist_state_e'(stat[1:0]), ST_DISPATCH);
        check_wei("status level", {11'h0, stat[20:16]}, 16'd16);

        // Stray gets on PECs without an offer
        @(posedge clk);
        get_wei <= 8'hFE;
        @(posedge clk);
        get_wei <= '0;
        read_status(stat);
        check_pec("status pec_idx", stat[6:4], 3'd0);
        check_wei("status level", {11'h0, stat[20:16]}, 16'd16);
        check_bit("rdy_wei[0]", rdy_wei[0], 1'b1);

        // PEC 0 takes its weight, next offer goes to PEC 1
        @(posedge clk);
        get_wei <= 8'h01;
        @(posedge clk);
        get_wei <= '0;
        wait_offer();
        check_pec("pec_idx", pec_index(rdy_wei), 3'd1);
        check_wei("wei_data", wei_data, golden[0][15:0]);

        // Abort mid-round, then restart at PEC 0
        apb_write(`WDIST_ADDR_CMD, {30'h0, CMD_ABORT}, 1'b0);
        read_status(stat);
        check_state(wdist_state_e'(stat[1:0]), ST_IDLE);
        check_pec("status pec_idx", stat[6:4], 3'd0);
        check_bit("status level nonzero", |stat[20:16], 1'b0);
        check_bit("rdy_wei any", |rdy_wei, 1'b0);
        apb_write(`WDIST_ADDR_WEI, golden[1], 1'b0);
        apb_write(`WDIST_ADDR_CMD, {30'h0, CMD_START}, 1'b0);
        wait_offer();
        check_pec("pec_idx", pec_index(rdy_wei), 3'd0);
        check_wei("wei_data", wei_data, golden[1][15:0]);
        apb_write(`WDIST_ADDR_CMD, {30'h0, CMD_ABORT}, 1'b0);
        read_status(stat);
        check_state(wdist_state_e'(stat[1:0]), ST_IDLE);

        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wdist.f ====
+incdir+logic
logic/wdist_pkg.sv
logic/wdist_apb_regs.sv
logic/wdist_wei_fifo.sv
logic/wdist_cursor.sv
logic/wdist_ctrl_fsm.sv
logic/wdist_top.sv
tests/wdist_asserts.sv
tests/wdist_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the wdist testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=wdist_sim

verilator --binary --timing --assert -Wno-fatal \
    -f wdist.f \
    --top-module wdist_tb \
    -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

// ==== tests/wdist_golden.txt ====
// Entries 0..31: weights loaded over APB, in FIFO order
// Entries 32..63: per handout, bits 18:16 PEC index, bits 15:0 weight
// Entries 64..67: error accesses, bit 28 write, bits 27:24 addr, bits 23:0 data
// Entry 68: single weight used by the empty-FIFO stall test
00003A17 00004C29 00005E3B 00006F4D 00007061 00008173 00009285 0000A397
0000B4A9 0000C5BB 0000D6CD 0000E7DF 0000F8E1 000009F3 00001A05 00002B17
00003C29 00004D3B 00005E4D 00006F5F 00007071 00008183 00009295 0000A3A7
0000B4B9 0000C5CB 0000D6DD 0000E7EF 0000F801 00000913 00001A25 00002B37
// Round 0
00003A17 00014C29 00025E3B 00036F4D 00047061 00058173 00069285 0007A397
// Round 1
0000B4A9 0001C5BB 0002D6CD 0003E7DF 0004F8E1 000509F3 00061A05 00072B17
// Round 2
00003C29 00014D3B 00025E4D 00036F5F 00047071 00058183 00069295 0007A3A7
// Round 3
0000B4B9 0001C5CB 0002D6DD 0003E7EF 0004F801 00050913 00061A25 00072B37
// Full-FIFO write
1000BEEF
// START during dispatch
14000001
// Write to status
18000000
// Read of unmapped address
0C000000
// Stall test weight
00005A5A
